// File: hw/fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// program counter width, two bytes hi:lo
`define FETCH_PC_WIDTH 16

// program memory index bits
// 1024 words, indexed by the low bits of pc
`define FETCH_PROG_ADDR_BITS 10

// derived word count, handy for loops over the memory
`define FETCH_PROG_WORDS (1 << `FETCH_PROG_ADDR_BITS)

`endif

// File: hw/isa_pkg.sv
`default_nettype none

package isa_pkg;

  // opcode byte encodings
  // anything not listed runs as a nop
  typedef enum logic [7:0] {
    OP_NOP     = 8'h00,
    OP_SETHI   = 8'h01,
    OP_JMPLO   = 8'h02,
    OP_JMPLONG = 8'h03,
    OP_HALT    = 8'hFF
  } opcode_e;

  // one program word, opcode in the upper byte
  typedef struct packed {
    opcode_e    opcode;
    logic [7:0] operand;
  } instr_t;

  // decoder output, one-hot kind flags
  // all flags low means nop
  typedef struct packed {
    logic       is_sethi;
    logic       is_jmplo;
    logic       is_jmplong;
    logic       is_halt;
    logic [7:0] operand;
    // whole word, kept for retire reporting
    instr_t     raw;
  } decoded_t;

endpackage : isa_pkg

`default_nettype wire

// File: hw/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // sequencer states
  // every instruction goes fetch, load, exec
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_FETCH = 2'd1,
    ST_LOAD  = 2'd2,
    ST_EXEC  = 2'd3
  } ctrl_state_e;

  // counter controls from the sequencer
  // strobes act at the next edge
  typedef struct packed {
    // advance by one
    logic       inc;
    // replace low byte only
    logic       local_jump;
    // hi from high temp, lo from operand
    logic       long_jump;
    // capture operand into high temp
    logic       hitmp_load;
    // jump target low byte or new high temp
    logic [7:0] operand;
  } pc_ctrl_t;

endpackage : fetch_pkg

`default_nettype wire

// File: hw/program_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module program_counter
  import fetch_pkg::*;
(
  input  wire logic                       clk,
  input  wire logic                       reset,
  input  wire pc_ctrl_t                   pc_ctrl,
  output logic [`FETCH_PC_WIDTH-1:0]      pc
);

  // count register and the held high byte
  logic [`FETCH_PC_WIDTH-1:0] pc_q;
  logic [7:0]                 hitmp_q;

  // high temp byte
  // written by sethi, read only by long jump
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      hitmp_q <= 8'h00;
    end
    else if (pc_ctrl.hitmp_load)
    begin
      hitmp_q <= pc_ctrl.operand;
    end
  end

  // count update
  // jumps win over inc, though the controller never mixes them
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      pc_q <= '0;
    end
    else if (pc_ctrl.long_jump)
    begin
      // both bytes reload
      pc_q <= {hitmp_q, pc_ctrl.operand};
    end
    else if (pc_ctrl.local_jump)
    begin
      // page stays, low byte replaced
      pc_q <= {pc_q[`FETCH_PC_WIDTH-1:8], pc_ctrl.operand};
    end
    else if (pc_ctrl.inc)
    begin
      // wraps at full width
      pc_q <= pc_q + 1'b1;
    end
  end

  assign pc = pc_q;

  // sequencer issues at most one counter action per instruction
  a_one_action: assert property (
    @(posedge clk) disable iff (reset)
    $onehot0({pc_ctrl.inc, pc_ctrl.local_jump, pc_ctrl.long_jump})
  );

endmodule : program_counter

`default_nettype wire

// File: hw/program_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module program_ram
  import isa_pkg::*;
(
  input  wire logic                             clk,
  input  wire logic                             we,
  input  wire logic [`FETCH_PROG_ADDR_BITS-1:0] wr_addr,
  input  wire instr_t                           wr_data,
  input  wire logic                             rd_en,
  input  wire logic [`FETCH_PROG_ADDR_BITS-1:0] rd_addr,
  output instr_t                                rd_data
);

  // word storage, contents survive reset
  instr_t mem [`FETCH_PROG_WORDS];

  // loader write port
  always_ff @(posedge clk)
  begin
    if (we)
    begin
      mem[wr_addr] <= wr_data;
    end
  end

  // registered read, one cycle latency
  // holds its last word when rd_en is low
  always_ff @(posedge clk)
  begin
    if (rd_en)
    begin
      rd_data <= mem[rd_addr];
    end
  end

  // loading only happens while the sequencer is idle
  a_no_load_while_fetch: assert property (
    @(posedge clk) !(we && rd_en)
  );

endmodule : program_ram

`default_nettype wire

// File: hw/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder
  import isa_pkg::*;
(
  input  wire logic   clk,
  input  wire logic   reset,
  input  wire logic   ir_load,
  input  wire instr_t instr,
  output decoded_t    decoded
);

  // instruction register
  instr_t ir_q;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      // comes up holding a nop
      ir_q.opcode  <= OP_NOP;
      ir_q.operand <= 8'h00;
    end
    else if (ir_load)
    begin
      ir_q <= instr;
    end
  end

  // opcode decode off the held word
  // valid the cycle after ir_load
  always_comb
  begin
    decoded            = '0;
    decoded.operand    = ir_q.operand;
    decoded.raw        = ir_q;
    case (ir_q.opcode)
      OP_SETHI:   decoded.is_sethi   = 1'b1;
      OP_JMPLO:   decoded.is_jmplo   = 1'b1;
      OP_JMPLONG: decoded.is_jmplong = 1'b1;
      OP_HALT:    decoded.is_halt    = 1'b1;
      // nop and undefined codes, no flag
      default:    decoded.is_halt    = 1'b0;
    endcase
  end

  // captured word must come from loaded memory
  a_known_word: assert property (
    @(posedge clk) disable iff (reset)
    ir_load |-> !$isunknown(instr)
  );

endmodule : instr_decoder

`default_nettype wire

// File: hw/fetch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module fetch_ctrl
  import isa_pkg::*;
  import fetch_pkg::*;
(
  input  wire logic                       clk,
  input  wire logic                       reset,
  input  wire logic                       run,
  input  wire decoded_t                   decoded,
  input  wire logic [`FETCH_PC_WIDTH-1:0] pc,
  output logic                            rd_en,
  output logic                            ir_load,
  output pc_ctrl_t                        pc_ctrl,
  output logic                            retire,
  output logic [`FETCH_PC_WIDTH-1:0]      retire_pc,
  output instr_t                          retire_instr,
  output logic                            done,
  output logic                            busy
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        exec;
  logic        is_jump;

  // state register
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state_q <= ST_IDLE;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  // next state
  // run only matters in idle, halt drops back there
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:  state_d = run ? ST_FETCH : ST_IDLE;
      ST_FETCH: state_d = ST_LOAD;
      ST_LOAD:  state_d = ST_EXEC;
      ST_EXEC:  state_d = decoded.is_halt ? ST_IDLE : ST_FETCH;
      default:  state_d = ST_IDLE;
    endcase
  end

  assign exec    = (state_q == ST_EXEC);
  assign is_jump = decoded.is_jmplo | decoded.is_jmplong;

  // memory read issued in fetch, word captured in load
  assign rd_en   = (state_q == ST_FETCH);
  assign ir_load = (state_q == ST_LOAD);

  // exactly one counter action per exec
  // halt leaves pc alone so a rerun repeats it
  assign pc_ctrl.inc        = exec & ~is_jump & ~decoded.is_halt;
  assign pc_ctrl.local_jump = exec & decoded.is_jmplo;
  assign pc_ctrl.long_jump  = exec & decoded.is_jmplong;
  assign pc_ctrl.hitmp_load = exec & decoded.is_sethi;
  assign pc_ctrl.operand    = decoded.operand;

  // pc still points at this instruction during exec
  assign retire       = exec;
  assign retire_pc    = pc;
  assign retire_instr = decoded.raw;
  assign done         = exec & decoded.is_halt;
  assign busy         = (state_q != ST_IDLE);

  // counter only moves at the end of an instruction
  // so the fetched address is the one retired
  a_pc_held: assert property (
    @(posedge clk) disable iff (reset)
    (state_q == ST_LOAD || state_q == ST_EXEC) |-> $stable(pc)
  );

endmodule : fetch_ctrl

`default_nettype wire

// File: hw/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module fetch_unit
  import isa_pkg::*;
  import fetch_pkg::*;
(
  input  wire logic                             clk,
  input  wire logic                             reset,
  input  wire logic                             run,
  // loader port, only written while busy is low
  input  wire logic                             prog_we,
  input  wire logic [`FETCH_PROG_ADDR_BITS-1:0] prog_addr,
  input  wire instr_t                           prog_data,
  output logic [`FETCH_PC_WIDTH-1:0]            pc,
  output logic                                  retire,
  output logic [`FETCH_PC_WIDTH-1:0]            retire_pc,
  output instr_t                                retire_instr,
  output logic                                  done,
  output logic                                  busy
);

  pc_ctrl_t pc_ctrl;
  decoded_t decoded;
  instr_t   rd_data;
  logic     rd_en;
  logic     ir_load;

  program_counter program_counter_i (
    .clk     (clk),
    .reset   (reset),
    .pc_ctrl (pc_ctrl),
    .pc      (pc)
  );

  // memory indexed by the low pc bits, high bits alias
  program_ram program_ram_i (
    .clk     (clk),
    .we      (prog_we),
    .wr_addr (prog_addr),
    .wr_data (prog_data),
    .rd_en   (rd_en),
    .rd_addr (pc[`FETCH_PROG_ADDR_BITS-1:0]),
    .rd_data (rd_data)
  );

  instr_decoder instr_decoder_i (
    .clk     (clk),
    .reset   (reset),
    .ir_load (ir_load),
    .instr   (rd_data),
    .decoded (decoded)
  );

  fetch_ctrl fetch_ctrl_i (
    .clk          (clk),
    .reset        (reset),
    .run          (run),
    .decoded      (decoded),
    .pc           (pc),
    .rd_en        (rd_en),
    .ir_load      (ir_load),
    .pc_ctrl      (pc_ctrl),
    .retire       (retire),
    .retire_pc    (retire_pc),
    .retire_instr (retire_instr),
    .done         (done),
    .busy         (busy)
  );

endmodule : fetch_unit

`default_nettype wire

// File: bench/fetch_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module fetch_unit_tb
  import isa_pkg::*;
();

  // one expected retire
  typedef struct packed {
    logic [`FETCH_PC_WIDTH-1:0] pc;
    instr_t                     instr;
  } retire_t;

  logic                             clk;
  logic                             reset;
  logic                             run;
  logic                             prog_we;
  logic [`FETCH_PROG_ADDR_BITS-1:0] prog_addr;
  instr_t                           prog_data;
  logic [`FETCH_PC_WIDTH-1:0]       pc;
  logic                             retire;
  logic [`FETCH_PC_WIDTH-1:0]       retire_pc;
  instr_t                           retire_instr;
  logic                             done;
  logic                             busy;

  // shadow of the program memory, mirrors every write
  instr_t                     image [`FETCH_PROG_WORDS];
  retire_t                    exp_q [$];
  // reference machine state, carried across runs like the DUT
  logic [`FETCH_PC_WIDTH-1:0] ref_pc;
  logic [7:0]                 ref_hitmp;
  integer                     seed;
  integer                     test_errors;
  integer                     tests_run;
  integer                     tests_failed;
  string                      cur_name;

  fetch_unit fetch_unit_i (
    .clk          (clk),
    .reset        (reset),
    .run          (run),
    .prog_we      (prog_we),
    .prog_addr    (prog_addr),
    .prog_data    (prog_data),
    .pc           (pc),
    .retire       (retire),
    .retire_pc    (retire_pc),
    .retire_instr (retire_instr),
    .done         (done),
    .busy         (busy)
  );

  // 8 ns period
  initial clk = 1'b0;
  always #4 clk = ~clk;

  function automatic instr_t make_word(input logic [7:0] op, input logic [7:0] arg);
    return instr_t'({op, arg});
  endfunction

  // reference model, steps the shadow image from ref_pc until halt
  // fills exp_q and leaves ref_pc at the final pc
  function automatic void predict_retires();
    instr_t w;
    int     steps;
    logic   halted;
    steps  = 0;
    halted = 1'b0;
    exp_q.delete();
    while (!halted && steps < 4000)
    begin
      // memory sees only the low pc bits
      w = image[ref_pc[`FETCH_PROG_ADDR_BITS-1:0]];
      exp_q.push_back(retire_t'{pc: ref_pc, instr: w});
      steps++;
      case (w.opcode)
        OP_SETHI:
        begin
          ref_hitmp = w.operand;
          ref_pc    = ref_pc + 16'd1;
        end
        OP_JMPLO:   ref_pc = {ref_pc[15:8], w.operand};
        OP_JMPLONG: ref_pc = {ref_hitmp, w.operand};
        OP_HALT:    halted = 1'b1;
        // nop and undefined codes
        default:    ref_pc = ref_pc + 16'd1;
      endcase
    end
  endfunction

  task automatic apply_reset();
    @(posedge clk);
    reset <= 1'b1;
    repeat (4) @(posedge clk);
    reset     <= 1'b0;
    ref_pc    = '0;
    ref_hitmp = 8'h00;
  endtask

  // copy a slice of the shadow image into the DUT
  task automatic load_program(input int first, input int count);
    for (int i = 0; i < count; i++)
    begin
      @(posedge clk);
      prog_we   <= 1'b1;
      prog_addr <= first + i;
      prog_data <= image[first + i];
    end
    @(posedge clk);
    prog_we <= 1'b0;
  endtask

  // forward-only program, every jump lands past its own slot
  task automatic make_random_program(input int len);
    int         kind;
    int         target;
    logic [7:0] arg;
    for (int i = 0; i < len - 1; i++)
    begin
      kind   = {$random(seed)} % 8;
      target = i + 1 + ({$random(seed)} % (len - 1 - i));
      arg    = $random(seed);
      case (kind)
        // undefined opcode, runs as nop
        0: image[i] = make_word(8'h10 + ({$random(seed)} % 64), arg);
        // page 0, 4 or 8, all alias onto the same words
        1: image[i] = make_word(8'h01, 8'(({$random(seed)} % 3) * 4));
        2: image[i] = make_word(8'h02, target[7:0]);
        3: image[i] = make_word(8'h03, target[7:0]);
        default: image[i] = make_word(8'h00, arg);
      endcase
    end
    image[len - 1] = make_word(8'hFF, 8'h00);
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (test_errors == 0)
    begin
      $display("test %s: ok", name);
    end
    else
    begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, test_errors);
    end
  endtask

  // predict, pulse run, wait for done, then check the final state
  task automatic run_and_check(input string name);
    int   limit;
    int   cycles;
    logic seen;
    cur_name    = name;
    test_errors = 0;
    predict_retires();
    // three cycles per instruction plus slack
    limit  = 3 * exp_q.size() + 20;
    cycles = 0;
    seen   = 1'b0;
    @(posedge clk);
    run <= 1'b1;
    @(posedge clk);
    run <= 1'b0;
    while (!seen && cycles < limit)
    begin
      @(negedge clk);
      cycles++;
      if (done)
        seen = 1'b1;
    end
    if (!seen)
    begin
      $display("%s: done never came within %0d cycles", name, limit);
      test_errors++;
    end
    @(negedge clk);
    if (busy !== 1'b0)
    begin
      $display("** Error %s: busy after done expected 0 actual %b", name, busy);
      test_errors++;
    end
    if (exp_q.size() != 0)
    begin
      $display("%s: %0d expected retires never showed up", name, exp_q.size());
      test_errors++;
    end
    if (pc !== ref_pc)
    begin
      $display("** Error %s: final pc expected %h actual %h", name, ref_pc, pc);
      test_errors++;
    end
    report_test(name);
  endtask

  // retire checker, outputs settled mid-cycle
  always @(negedge clk)
  begin : check_retire
    retire_t e;
    if (retire)
    begin
      if (busy !== 1'b1)
      begin
        $display("** Error %s: busy expected 1 actual %b", cur_name, busy);
        test_errors++;
      end
      if (exp_q.size() == 0)
      begin
        $display("%s: retire at pc %h with nothing left to expect", cur_name, retire_pc);
        test_errors++;
      end
      else
      begin
        e = exp_q.pop_front();
        if (retire_pc !== e.pc)
        begin
          $display("** Error %s: retire_pc expected %h actual %h", cur_name, e.pc, retire_pc);
          test_errors++;
        end
        if (retire_instr !== e.instr)
        begin
          $display("** Error %s: retire_instr expected %h actual %h",
                   cur_name, e.instr, retire_instr);
          test_errors++;
        end
        if (done !== (e.instr.opcode == OP_HALT))
        begin
          $display("** Error %s: done expected %b actual %b",
                   cur_name, (e.instr.opcode == OP_HALT), done);
          test_errors++;
        end
      end
    end
    else if (done)
    begin
      $display("%s: done raised without a retire", cur_name);
      test_errors++;
    end
  end

  initial
  begin
    reset        = 1'b1;
    run          = 1'b0;
    prog_we      = 1'b0;
    prog_addr    = '0;
    prog_data    = '0;
    seed         = 32'hbde5;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    cur_name     = "reset_state";
    ref_pc       = '0;
    ref_hitmp    = 8'h00;
    repeat (4) @(posedge clk);
    reset <= 1'b0;

    // idle after reset, nothing moves without run
    repeat (10)
    begin
      @(negedge clk);
      if (pc !== '0)
      begin
        $display("** Error reset_state: pc expected %h actual %h", 16'h0000, pc);
        test_errors++;
      end
      if (retire !== 1'b0 || done !== 1'b0 || busy !== 1'b0)
      begin
        $display("** Error reset_state: retire/done/busy expected 000 actual %b%b%b",
                 retire, done, busy);
        test_errors++;
      end
    end
    report_test("reset_state");

    // halt fill, operand mixes all address bits
    for (int a = 0; a < `FETCH_PROG_WORDS; a++)
      image[a] = make_word(8'hFF, a[7:0] ^ {a[9:8], a[9:8], a[9:8], a[9:8]});
    load_program(0, `FETCH_PROG_WORDS);

    // straight line nops
    apply_reset();
    for (int i = 0; i < 6; i++)
      image[i] = make_word(8'h00, 8'(i * 17));
    image[6] = make_word(8'hFF, 8'h5a);
    load_program(0, 7);
    run_and_check("straight_line");

    // long jump into page 12, then a local jump inside it
    apply_reset();
    image[0]      = make_word(8'h01, 8'h12);
    image[1]      = make_word(8'h03, 8'h40);
    image[10'h240] = make_word(8'h02, 8'h80);
    image[10'h280] = make_word(8'hFF, 8'h00);
    load_program(0, 2);
    load_program(10'h240, 1);
    load_program(10'h280, 1);
    run_and_check("local_jump");

    // target past 1023, memory index wraps to 0x310
    apply_reset();
    image[0]       = make_word(8'h01, 8'h07);
    image[1]       = make_word(8'h03, 8'h10);
    image[10'h310] = make_word(8'h00, 8'h00);
    image[10'h311] = make_word(8'hFF, 8'h00);
    load_program(0, 2);
    load_program(10'h310, 2);
    run_and_check("long_jump");

    for (int n = 0; n < 3; n++)
    begin
      apply_reset();
      make_random_program(40);
      load_program(0, 40);
      run_and_check($sformatf("random_forward_%0d", n));
    end

    // no reset, pc still sits on the halt
    run_and_check("rerun_after_halt");

    $display("tests run %0d, failed %0d", tests_run, tests_failed);
    if (tests_failed == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule : fetch_unit_tb

`default_nettype wire

// File: vlog.f
+incdir+hw
hw/isa_pkg.sv
hw/fetch_pkg.sv
hw/program_counter.sv
hw/program_ram.sv
hw/instr_decoder.sv
hw/fetch_ctrl.sv
hw/fetch_unit.sv
bench/fetch_unit_tb.sv
